// File: compile.f
src/rv_pkg.sv
src/inst_fetch.sv
src/inst_decode.sv
src/reg_file.sv
src/exec_unit.sv
src/core_top.sv
tb/tb_core.sv

// File: tb/tb_core.sv
`timescale 1ns/1ps

module tb_core;

    import rv_pkg::*;

    localparam logic [31:0] RESET_PC   = 32'h8000_0000;
    localparam logic [31:0] EBREAK     = 32'h0010_0073;
    localparam int          WORD_LIMIT = 500;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] in_inst;
    logic        in_ready;
    logic        commit_valid;
    logic [31:0] commit_pc;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;
    logic        commit_ready;
    logic        halted;

    logic [31:0] prog[$];
    int          gaps[$];
    logic [31:0] exp_pc[$];
    logic [4:0]  exp_rd[$];
    logic [31:0] exp_data[$];
    logic [31:0] model_regs[32];
    bit          ready_pat[256];
    int          pat_idx;
    bit          run_on;
    int          ebreak_idx;
    int          checks;
    int          errors;
    int          timeouts;

    core_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_inst      (in_inst),
        .in_ready     (in_ready),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_ready (commit_ready),
        .halted       (halted)
    );

    always #2 clk = ~clk;

    // random back-pressure on the commit port.
    always @(negedge clk) begin
        if (run_on) begin
            commit_ready = ready_pat[pat_idx];
            pat_idx = (pat_idx + 1) % 256;
        end
    end

    // ========================================================================
    // instruction building and reference model
    // ========================================================================

    function automatic logic [31:0] make_op_imm(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd);
        inst_word_u w;
        w.i.imm12  = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = OP_IMM;
        return w;
    endfunction

    function automatic logic [31:0] make_upper(input logic [6:0] op, input logic [19:0] imm,
                                               input logic [4:0] rd);
        inst_word_u w;
        w.u.imm20  = imm;
        w.u.rd     = rd;
        w.u.opcode = op;
        return w;
    endfunction

    // returns {rd, data} and updates the model registers.
    function automatic logic [36:0] ref_exec(input logic [31:0] word, input logic [31:0] pc);
        inst_word_u  w;
        logic [4:0]  rd;
        logic [31:0] data;
        w    = word;
        rd   = 5'd0;
        data = 32'd0;
        if ((w.i.opcode == OP_IMM) && (w.i.funct3 == 3'b000)) begin
            rd   = w.i.rd;
            data = model_regs[w.i.rs1] + {{20{w.i.imm12[11]}}, w.i.imm12};
        end else if (w.u.opcode == OP_LUI) begin
            rd   = w.u.rd;
            data = {w.u.imm20, 12'h000};
        end else if (w.u.opcode == OP_AUIPC) begin
            rd   = w.u.rd;
            data = pc + {w.u.imm20, 12'h000};
        end
        if (rd != 5'd0) begin
            model_regs[rd] = data;
        end
        return {rd, data};
    endfunction

    task automatic build_program();
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [11:0] imm12;
        logic [19:0] imm20;
        prog.push_back(make_op_imm(12'd5, 5'd0, 3'b000, 5'd1));
        prog.push_back(make_op_imm(12'hffd, 5'd1, 3'b000, 5'd1));
        prog.push_back(make_op_imm(12'h800, 5'd1, 3'b000, 5'd2));
        prog.push_back(make_op_imm(12'd7, 5'd1, 3'b000, 5'd0));
        prog.push_back(make_op_imm(12'd1, 5'd0, 3'b000, 5'd3));
        prog.push_back(make_upper(OP_LUI, 20'hfffff, 5'd2));
        prog.push_back(make_upper(OP_AUIPC, 20'h12345, 5'd3));
        prog.push_back(make_op_imm(12'd1, 5'd3, 3'b000, 5'd3));
        prog.push_back(make_op_imm(12'd4, 5'd2, 3'b010, 5'd1));
        prog.push_back(32'h0020_81b3);
        prog.push_back(32'h0000_2083);
        // ecall shares the system opcode but is not a halt.
        prog.push_back(32'h0000_0073);
        prog.push_back(make_op_imm(12'h7ff, 5'd2, 3'b000, 5'd2));
        for (int n = 0; n < 60; n++) begin
            kind  = $urandom_range(9, 0);
            rd    = 5'($urandom_range(3, 0));
            rs1   = 5'($urandom_range(3, 0));
            imm12 = 12'($urandom);
            imm20 = 20'($urandom);
            if (kind <= 5) begin
                prog.push_back(make_op_imm(imm12, rs1, 3'b000, rd));
            end else if (kind == 6) begin
                prog.push_back(make_upper(OP_LUI, imm20, rd));
            end else if (kind == 7) begin
                prog.push_back(make_upper(OP_AUIPC, imm20, rd));
            end else if (kind == 8) begin
                prog.push_back(make_op_imm(imm12, rs1, 3'($urandom_range(7, 1)), rd));
            end else begin
                prog.push_back({25'($urandom), 7'b0110011});
            end
        end
        ebreak_idx = prog.size();
        prog.push_back(EBREAK);
        for (int n = 0; n < 4; n++) begin
            prog.push_back(make_op_imm(12'd9, 5'd1, 3'b000, 5'd1));
        end
        for (int n = 0; n < prog.size(); n++) begin
            gaps.push_back(($urandom_range(3, 0) == 0) ? $urandom_range(3, 1) : 0);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // ========================================================================
    // stimulus and comparison
    // ========================================================================

    task automatic drive_words();
        int cycles;
        bit sent;
        for (int i = 0; i < prog.size(); i++) begin
            in_valid = 1'b0;
            repeat (gaps[i]) @(negedge clk);
            in_valid = 1'b1;
            in_inst  = prog[i];
            sent     = 1'b0;
            cycles   = 0;
            while (!sent && (cycles < ((i <= ebreak_idx) ? WORD_LIMIT : 20))) begin
                @(posedge clk);
                sent = in_ready;
                cycles++;
                @(negedge clk);
            end
            if (!sent) begin
                in_valid = 1'b0;
                // words behind the ebreak are expected to be refused.
                if (i <= ebreak_idx) begin
                    $display("timed out offering word %0d, in_ready never rose", i);
                    timeouts++;
                end
                return;
            end
        end
        in_valid = 1'b0;
    endtask

    initial begin : commit_compare
        forever begin
            @(posedge clk);
            if (rst_n && commit_valid && commit_ready) begin
                if (exp_pc.size() == 0) begin
                    errors++;
                    $display("unexpected commit at %0t with pc %h", $time, commit_pc);
                end else begin
                    check_value("commit_pc", commit_pc, exp_pc.pop_front());
                    check_value("commit_rd", commit_rd, exp_rd.pop_front());
                    check_value("commit_data", commit_data, exp_data.pop_front());
                end
            end
        end
    end

    initial begin : main_seq
        int          cycles;
        logic [36:0] res;
        void'($urandom(32'h756a_d0a8));
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_inst      = 32'd0;
        commit_ready = 1'b1;
        run_on       = 1'b0;
        pat_idx      = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'd0;
        end
        for (int n = 0; n < 256; n++) begin
            ready_pat[n] = ($urandom_range(9, 0) >= 3);
        end
        build_program();
        for (int k = 0; k <= ebreak_idx; k++) begin
            res = ref_exec(prog[k], RESET_PC + 32'(4 * k));
            exp_pc.push_back(RESET_PC + 32'(4 * k));
            exp_rd.push_back(res[36:32]);
            exp_data.push_back(res[31:0]);
        end
        repeat (2) @(posedge clk);
        run_on = 1'b1;
        @(negedge clk);
        check_value("commit_valid", commit_valid, 1'b0);
        check_value("halted", halted, 1'b0);
        check_value("in_ready", in_ready, 1'b1);
        rst_n = 1'b1;
        fork
            drive_words();
        join_none
        cycles = 0;
        while (!halted && (cycles < 4000)) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            timeouts++;
            $display("timed out waiting for halted after the ebreak");
        end else if (exp_pc.size() != 0) begin
            errors++;
            $display("%0d expected commits never arrived", exp_pc.size());
        end
        // nothing may commit once the core has halted.
        if (halted) begin
            cycles = 0;
            while (cycles < 40) begin
                @(negedge clk);
                check_value("halted", halted, 1'b1);
                check_value("in_ready", in_ready, 1'b0);
                check_value("commit_valid", commit_valid, 1'b0);
                cycles++;
            end
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: src/core_top.sv
`timescale 1ns/1ps

module core_top #(
    parameter logic [31:0] RESET_PC    = 32'h8000_0000,
    parameter int          QUEUE_DEPTH = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic [31:0] in_inst,
    output logic        in_ready,
    output logic        commit_valid,
    output logic [31:0] commit_pc,
    output logic [4:0]  commit_rd,
    output logic [31:0] commit_data,
    input  logic        commit_ready,
    output logic        halted
);

    import rv_pkg::*;

    // ========================================================================
    // stage links
    // ========================================================================

    logic        f_valid;
    logic [31:0] f_inst;
    logic [31:0] f_pc;
    logic        f_ready;
    logic        halt_req;
    logic [4:0]  rs1_addr;
    logic [31:0] rs1_data;
    logic        x_busy;
    logic [4:0]  x_rd;
    logic        d_valid;
    cmd_e        d_cmd;
    logic [31:0] d_src1;
    logic [31:0] d_src2;
    logic [4:0]  d_rd;
    logic [31:0] d_pc;
    logic        d_ready;
    logic        wr_en;
    logic [4:0]  wr_addr;
    logic [31:0] wr_data;

    inst_fetch #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) fetch0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_inst  (in_inst),
        .in_ready (in_ready),
        .halt_req (halt_req),
        .f_valid  (f_valid),
        .f_inst   (f_inst),
        .f_pc     (f_pc),
        .f_ready  (f_ready)
    );

    inst_decode decode0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .f_valid  (f_valid),
        .f_inst   (f_inst),
        .f_pc     (f_pc),
        .f_ready  (f_ready),
        .rs1_addr (rs1_addr),
        .rs1_data (rs1_data),
        .x_busy   (x_busy),
        .x_rd     (x_rd),
        .halt_req (halt_req),
        .d_valid  (d_valid),
        .d_cmd    (d_cmd),
        .d_src1   (d_src1),
        .d_src2   (d_src2),
        .d_rd     (d_rd),
        .d_pc     (d_pc),
        .d_ready  (d_ready)
    );

    reg_file regs0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs1_data (rs1_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    exec_unit exec0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .d_valid      (d_valid),
        .d_cmd        (d_cmd),
        .d_src1       (d_src1),
        .d_src2       (d_src2),
        .d_rd         (d_rd),
        .d_pc         (d_pc),
        .d_ready      (d_ready),
        .x_busy       (x_busy),
        .x_rd         (x_rd),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_ready (commit_ready),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .halted       (halted)
    );

endmodule

// File: src/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         d_valid,
    input  rv_pkg::cmd_e d_cmd,
    input  logic [31:0]  d_src1,
    input  logic [31:0]  d_src2,
    input  logic [4:0]   d_rd,
    input  logic [31:0]  d_pc,
    output logic         d_ready,
    output logic         x_busy,
    output logic [4:0]   x_rd,
    output logic         commit_valid,
    output logic [31:0]  commit_pc,
    output logic [4:0]   commit_rd,
    output logic [31:0]  commit_data,
    input  logic         commit_ready,
    output logic         wr_en,
    output logic [4:0]   wr_addr,
    output logic [31:0]  wr_data,
    output logic         halted
);

    import rv_pkg::*;

    logic [31:0] result;
    logic        commit_halt;
    logic        load;
    logic        retire;

    assign d_ready = !commit_valid || commit_ready;
    assign load    = d_valid && d_ready;
    assign retire  = commit_valid && commit_ready;

    always_comb begin
        case (d_cmd)
            CMD_ADD: result = d_src1 + d_src2;
            CMD_EQU: result = d_src1;
            default: result = 32'd0;
        endcase
    end

    // pending destination, seen by the decode hazard check.
    assign x_busy = commit_valid;
    assign x_rd   = commit_rd;

    // write back together with the commit.
    assign wr_en   = retire && (commit_rd != 5'd0);
    assign wr_addr = commit_rd;
    assign wr_data = commit_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            if (load) begin
                commit_valid <= 1'b1;
            end else if (commit_ready) begin
                commit_valid <= 1'b0;
            end
            if (retire && commit_halt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            commit_pc   <= d_pc;
            commit_rd   <= d_rd;
            commit_data <= result;
            commit_halt <= (d_cmd == CMD_HALT);
        end
    end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_addr,
    output logic [31:0] rs1_data,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data
);

    // x0 has no storage.
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];

endmodule

// File: src/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         f_valid,
    input  logic [31:0]  f_inst,
    input  logic [31:0]  f_pc,
    output logic         f_ready,
    output logic [4:0]   rs1_addr,
    input  logic [31:0]  rs1_data,
    input  logic         x_busy,
    input  logic [4:0]   x_rd,
    output logic         halt_req,
    output logic         d_valid,
    output rv_pkg::cmd_e d_cmd,
    output logic [31:0]  d_src1,
    output logic [31:0]  d_src2,
    output logic [4:0]   d_rd,
    output logic [31:0]  d_pc,
    input  logic         d_ready
);

    import rv_pkg::*;

    inst_word_u  word;
    logic        is_addi;
    logic        is_lui;
    logic        is_auipc;
    logic        is_ebreak;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic        hazard;
    logic        stopped;
    logic        load;
    cmd_e        nxt_cmd;
    logic [31:0] nxt_src1;
    logic [31:0] nxt_src2;
    logic [4:0]  nxt_rd;

    assign word = f_inst;

    // ========================================================================
    // field decode
    // ========================================================================

    // op-imm with a non-zero funct3 falls through to a no-op.
    assign is_addi   = (word.i.opcode == OP_IMM) && (word.i.funct3 == 3'b000);
    assign is_lui    = (word.u.opcode == OP_LUI);
    assign is_auipc  = (word.u.opcode == OP_AUIPC);
    // only the exact ebreak encoding halts.
    assign is_ebreak = (word.i.opcode == OP_SYSTEM) && (word.i.imm12 == 12'h001) &&
                       (word.i.rs1 == 5'd0) && (word.i.funct3 == 3'b000) &&
                       (word.i.rd == 5'd0);

    assign imm_i = {{20{word.i.imm12[11]}}, word.i.imm12};
    assign imm_u = {word.u.imm20, 12'h000};

    assign rs1_addr = is_addi ? word.i.rs1 : 5'd0;

    always_comb begin
        nxt_cmd  = CMD_NONE;
        nxt_src1 = 32'd0;
        nxt_src2 = 32'd0;
        nxt_rd   = 5'd0;
        if (is_addi) begin
            nxt_cmd  = CMD_ADD;
            nxt_src1 = rs1_data;
            nxt_src2 = imm_i;
            nxt_rd   = word.i.rd;
        end else if (is_lui) begin
            nxt_cmd  = CMD_EQU;
            nxt_src1 = imm_u;
            nxt_rd   = word.u.rd;
        end else if (is_auipc) begin
            nxt_cmd  = CMD_ADD;
            nxt_src1 = f_pc;
            nxt_src2 = imm_u;
            nxt_rd   = word.u.rd;
        end else if (is_ebreak) begin
            nxt_cmd = CMD_HALT;
        end
    end

    // ========================================================================
    // hazard stall and handshake
    // ========================================================================

    // rs1 still pending in this stage or in execute.
    assign hazard = is_addi && (word.i.rs1 != 5'd0) &&
                    ((d_valid && (d_rd == word.i.rs1)) ||
                     (x_busy && (x_rd == word.i.rs1)));

    assign f_ready  = !stopped && !hazard && (!d_valid || d_ready);
    assign load     = f_valid && f_ready;
    assign halt_req = d_valid && d_ready && (d_cmd == CMD_HALT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
            stopped <= 1'b0;
        end else begin
            if (load) begin
                d_valid <= 1'b1;
            end else if (d_ready) begin
                d_valid <= 1'b0;
            end
            // nothing behind an ebreak gets in.
            if (load && is_ebreak) begin
                stopped <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            d_cmd  <= nxt_cmd;
            d_src1 <= nxt_src1;
            d_src2 <= nxt_src2;
            d_rd   <= nxt_rd;
            d_pc   <= f_pc;
        end
    end

endmodule

// File: src/inst_fetch.sv
`timescale 1ns/1ps

module inst_fetch #(
    parameter logic [31:0] RESET_PC    = 32'h8000_0000,
    parameter int          QUEUE_DEPTH = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic [31:0] in_inst,
    output logic        in_ready,
    input  logic        halt_req,
    output logic        f_valid,
    output logic [31:0] f_inst,
    output logic [31:0] f_pc,
    input  logic        f_ready
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [31:0]      inst_q [QUEUE_DEPTH];
    logic [31:0]      pc_q   [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [31:0]      next_pc;
    logic             stopped;
    logic             full;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full     = (count == CNT_W'(QUEUE_DEPTH));
    assign in_ready = !full && !stopped && !halt_req;
    assign push     = in_valid && in_ready;
    assign f_valid  = (count != '0);
    assign pop      = f_valid && f_ready;
    assign f_inst   = inst_q[rd_ptr];
    assign f_pc     = pc_q[rd_ptr];

    // each word is stored with the pc it was given.
    always_ff @(posedge clk) begin
        if (push) begin
            inst_q[wr_ptr] <= in_inst;
            pc_q[wr_ptr]   <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            next_pc <= RESET_PC;
            stopped <= 1'b0;
        end else if (halt_req) begin
            // drop everything queued behind the ebreak.
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            stopped <= 1'b1;
        end else begin
            if (push) begin
                wr_ptr  <= ptr_inc(wr_ptr);
                next_pc <= next_pc + 32'd4;
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

    // ========================================================================
    // rv32 base opcodes
    // ========================================================================

    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // ========================================================================
    // execute commands
    // ========================================================================

    // CMD_EQU passes src1 straight to the result.
    typedef enum logic [1:0] {
        CMD_NONE = 2'd0,
        CMD_ADD  = 2'd1,
        CMD_EQU  = 2'd2,
        CMD_HALT = 2'd3
    } cmd_e;

    // ========================================================================
    // instruction word layouts
    // ========================================================================

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // same 32 bits seen as either format.
    typedef union packed {
        i_fmt_t i;
        u_fmt_t u;
    } inst_word_u;

endpackage
